//--- decode_stage.sv
// instruction decode, operand forwarding, load-use interlock
// and the decode/execute register
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                clk,
    input  logic                arst_n_i,
    input  mips_pkg::word_t     instr_i,
    input  mips_pkg::word_t     rd1_data_i,
    input  mips_pkg::word_t     rd2_data_i,
    input  logic                ex_wr_en_i,
    input  logic                ex_is_load_i,
    input  mips_pkg::reg_addr_t ex_wr_addr_i,
    input  mips_pkg::word_t     ex_result_i,
    input  logic                mem_wr_en_i,
    input  mips_pkg::reg_addr_t mem_wr_addr_i,
    input  mips_pkg::word_t     mem_result_i,
    output mips_pkg::reg_addr_t rd1_addr_o,
    output mips_pkg::reg_addr_t rd2_addr_o,
    output logic                stall_o,
    dec_ex_if.src               dec_o
);

    mips_pkg::opcode_t   opcode;
    mips_pkg::funct_t    funct;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    mips_pkg::reg_addr_t wr_addr;
    mips_pkg::word_t     simm;
    mips_pkg::word_t     zimm;
    mips_pkg::word_t     fwd_a;
    mips_pkg::word_t     fwd_b;
    mips_pkg::alu_op_t   alu_op;
    logic                wr_en;
    logic                is_load;
    logic                is_store;
    logic                use_imm;
    logic                imm_zext;
    logic                uses_rs;
    logic                uses_rt;
    logic                load_use;

    assign opcode  = instr_i[31:26];
    assign rs      = instr_i[25:21];
    assign rt      = instr_i[20:16];
    assign rd      = instr_i[15:11];
    assign funct   = instr_i[5:0];
    assign simm    = {{16{instr_i[15]}}, instr_i[15:0]};
    assign zimm    = {16'h0000, instr_i[15:0]};
    assign wr_addr = (opcode == mips_pkg::OP_SPECIAL) ? rd : rt;

    always_comb begin
        alu_op   = mips_pkg::ALU_ADD;
        wr_en    = 1'b1;
        is_load  = 1'b0;
        is_store = 1'b0;
        use_imm  = 1'b1;
        imm_zext = 1'b0;
        uses_rs  = 1'b1;
        uses_rt  = 1'b0;
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                use_imm = 1'b0;
                uses_rt = 1'b1;
                case (funct)
                    mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                    // includes the all-zero NOP
                    default: begin
                        wr_en   = 1'b0;
                        uses_rs = 1'b0;
                        uses_rt = 1'b0;
                    end
                endcase
            end
            mips_pkg::OP_ADDIU: alu_op = mips_pkg::ALU_ADD;
            mips_pkg::OP_ANDI: begin
                alu_op   = mips_pkg::ALU_AND;
                imm_zext = 1'b1;
            end
            mips_pkg::OP_ORI: begin
                alu_op   = mips_pkg::ALU_OR;
                imm_zext = 1'b1;
            end
            mips_pkg::OP_LUI: begin
                alu_op   = mips_pkg::ALU_LUI;
                imm_zext = 1'b1;
                uses_rs  = 1'b0;
            end
            mips_pkg::OP_LW: is_load = 1'b1;
            mips_pkg::OP_SW: begin
                wr_en    = 1'b0;
                is_store = 1'b1;
                uses_rt  = 1'b1;
            end
            default: begin
                wr_en   = 1'b0;
                uses_rs = 1'b0;
            end
        endcase
    end

    // execute beats memory, register file covers writeback
    assign fwd_a = (rs == '0) ? rd1_data_i :
                   (ex_wr_en_i && ex_wr_addr_i == rs) ? ex_result_i :
                   (mem_wr_en_i && mem_wr_addr_i == rs) ? mem_result_i : rd1_data_i;
    assign fwd_b = (rt == '0) ? rd2_data_i :
                   (ex_wr_en_i && ex_wr_addr_i == rt) ? ex_result_i :
                   (mem_wr_en_i && mem_wr_addr_i == rt) ? mem_result_i : rd2_data_i;

    assign load_use = ex_is_load_i && ex_wr_en_i && ex_wr_addr_i != '0 &&
                      ((uses_rs && ex_wr_addr_i == rs) || (uses_rt && ex_wr_addr_i == rt));

    assign rd1_addr_o = rs;
    assign rd2_addr_o = rt;
    assign stall_o    = load_use;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_o.wr_en    <= 1'b0;
            dec_o.is_load  <= 1'b0;
            dec_o.is_store <= 1'b0;
        end else begin
            // bubble while the load is still in execute
            dec_o.wr_en    <= wr_en && !load_use;
            dec_o.is_load  <= is_load && !load_use;
            dec_o.is_store <= is_store && !load_use;
        end
    end

    always_ff @(posedge clk) begin
        dec_o.alu_op     <= alu_op;
        dec_o.a          <= fwd_a;
        dec_o.b          <= use_imm ? (imm_zext ? zimm : simm) : fwd_b;
        dec_o.store_data <= fwd_b;
        dec_o.wr_addr    <= wr_addr;
    end

    a_single_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
        stall_o |=> !stall_o);

endmodule

`default_nettype wire

//--- execute_stage.sv
// ALU, address generation and the execute/memory register
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                clk,
    input  logic                arst_n_i,
    dec_ex_if.dst               dec_i,
    output logic                ex_wr_en_o,
    output logic                ex_is_load_o,
    output mips_pkg::reg_addr_t ex_wr_addr_o,
    output mips_pkg::word_t     ex_result_o,
    ex_mem_if.src               exm_o
);

    mips_pkg::word_t alu_result;

    // loads and stores come through as ALU_ADD
    always_comb begin
        case (dec_i.alu_op)
            mips_pkg::ALU_SUB: alu_result = dec_i.a - dec_i.b;
            mips_pkg::ALU_AND: alu_result = dec_i.a & dec_i.b;
            mips_pkg::ALU_OR:  alu_result = dec_i.a | dec_i.b;
            mips_pkg::ALU_XOR: alu_result = dec_i.a ^ dec_i.b;
            mips_pkg::ALU_SLT: alu_result = {31'd0, $signed(dec_i.a) < $signed(dec_i.b)};
            mips_pkg::ALU_LUI: alu_result = {dec_i.b[15:0], 16'h0000};
            default:           alu_result = dec_i.a + dec_i.b;
        endcase
    end

    // forwarding and interlock view of this stage
    assign ex_wr_en_o   = dec_i.wr_en;
    assign ex_is_load_o = dec_i.is_load;
    assign ex_wr_addr_o = dec_i.wr_addr;
    assign ex_result_o  = alu_result;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exm_o.wr_en    <= 1'b0;
            exm_o.is_load  <= 1'b0;
            exm_o.is_store <= 1'b0;
        end else begin
            exm_o.wr_en    <= dec_i.wr_en;
            exm_o.is_load  <= dec_i.is_load;
            exm_o.is_store <= dec_i.is_store;
        end
    end

    always_ff @(posedge clk) begin
        exm_o.result     <= alu_result;
        exm_o.store_data <= dec_i.store_data;
        exm_o.wr_addr    <= dec_i.wr_addr;
    end

endmodule

`default_nettype wire

//--- fetch_stage.sv
// program counter, ROM strobe, fetch/decode instruction register
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter mips_pkg::word_t RESET_PC = '0
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            stall_i,
    input  mips_pkg::word_t rom_data_i,
    output mips_pkg::word_t rom_addr_o,
    output logic            rom_en_o,
    output mips_pkg::word_t instr_o
);

    mips_pkg::word_t pc;
    mips_pkg::word_t instr_q;
    logic            en_q;

    // first enabled cycle fetches RESET_PC, then step by one word
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc      <= RESET_PC;
            en_q    <= 1'b0;
            instr_q <= '0;
        end else begin
            en_q <= 1'b1;
            if (en_q && !stall_i) begin
                pc <= pc + 32'd4;
            end
            if (!stall_i) begin
                instr_q <= en_q ? rom_data_i : '0;
            end
        end
    end

    assign rom_addr_o = pc;
    assign rom_en_o   = en_q;
    assign instr_o    = instr_q;

    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        rom_addr_o[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- memory_stage.sv
// data RAM strobes, load return and the memory/writeback register
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
    input  logic                clk,
    input  logic                arst_n_i,
    ex_mem_if.dst               exm_i,
    input  mips_pkg::word_t     ram_rdata_i,
    output mips_pkg::word_t     ram_addr_o,
    output mips_pkg::word_t     ram_wdata_o,
    output logic                ram_en_o,
    output logic                ram_we_o,
    output logic                mem_wr_en_o,
    output mips_pkg::reg_addr_t mem_wr_addr_o,
    output mips_pkg::word_t     mem_result_o,
    output logic                wb_wr_en_o,
    output mips_pkg::reg_addr_t wb_wr_addr_o,
    output mips_pkg::word_t     wb_data_o
);

    mips_pkg::word_t mem_result;

    assign ram_addr_o  = exm_i.result;
    assign ram_wdata_o = exm_i.store_data;
    assign ram_en_o    = exm_i.is_load || exm_i.is_store;
    assign ram_we_o    = exm_i.is_store;

    // RAM read is combinational, so load data is ready this cycle
    assign mem_result    = exm_i.is_load ? ram_rdata_i : exm_i.result;
    assign mem_wr_en_o   = exm_i.wr_en;
    assign mem_wr_addr_o = exm_i.wr_addr;
    assign mem_result_o  = mem_result;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_wr_en_o <= 1'b0;
        end else begin
            wb_wr_en_o <= exm_i.wr_en;
        end
    end

    always_ff @(posedge clk) begin
        wb_wr_addr_o <= exm_i.wr_addr;
        wb_data_o    <= mem_result;
    end

    a_we_has_en: assert property (@(posedge clk) disable iff (!arst_n_i)
        ram_we_o |-> ram_en_o);

    a_ram_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        ram_en_o |-> ram_addr_o[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- mips_bus_if.sv
// decode/execute and execute/memory stage buses
`timescale 1ns/1ps
`default_nettype none

interface dec_ex_if;
    mips_pkg::alu_op_t   alu_op;
    mips_pkg::word_t     a;
    mips_pkg::word_t     b;
    mips_pkg::word_t     store_data;
    logic                is_load;
    logic                is_store;
    logic                wr_en;
    mips_pkg::reg_addr_t wr_addr;

    modport src (
        output alu_op, a, b, store_data, is_load, is_store, wr_en, wr_addr
    );
    modport dst (
        input alu_op, a, b, store_data, is_load, is_store, wr_en, wr_addr
    );
endinterface

interface ex_mem_if;
    // ALU value, or the byte address for loads and stores
    mips_pkg::word_t     result;
    mips_pkg::word_t     store_data;
    logic                is_load;
    logic                is_store;
    logic                wr_en;
    mips_pkg::reg_addr_t wr_addr;

    modport src (
        output result, store_data, is_load, is_store, wr_en, wr_addr
    );
    modport dst (
        input result, store_data, is_load, is_store, wr_en, wr_addr
    );
endinterface

`default_nettype wire

//--- mips_core.f
mips_pkg.sv
mips_bus_if.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
mips_core.sv
tb_mips_core.sv

//--- mips_core.sv
// five-stage MIPS core top level with ROM and RAM ports
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
    parameter mips_pkg::word_t RESET_PC = '0
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  mips_pkg::word_t rom_data_i,
    input  mips_pkg::word_t ram_rdata_i,
    output mips_pkg::word_t rom_addr_o,
    output logic            rom_en_o,
    output mips_pkg::word_t ram_addr_o,
    output mips_pkg::word_t ram_wdata_o,
    output logic            ram_en_o,
    output logic            ram_we_o
);

    mips_pkg::word_t     instr;
    logic                stall;
    mips_pkg::reg_addr_t rd1_addr;
    mips_pkg::reg_addr_t rd2_addr;
    mips_pkg::word_t     rd1_data;
    mips_pkg::word_t     rd2_data;
    logic                ex_wr_en;
    logic                ex_is_load;
    mips_pkg::reg_addr_t ex_wr_addr;
    mips_pkg::word_t     ex_result;
    logic                mem_wr_en;
    mips_pkg::reg_addr_t mem_wr_addr;
    mips_pkg::word_t     mem_result;
    logic                wb_wr_en;
    mips_pkg::reg_addr_t wb_wr_addr;
    mips_pkg::word_t     wb_data;

    dec_ex_if dec_ex ();
    ex_mem_if ex_mem ();

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .stall_i    (stall),
        .rom_data_i (rom_data_i),
        .rom_addr_o (rom_addr_o),
        .rom_en_o   (rom_en_o),
        .instr_o    (instr)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rd1_addr_i (rd1_addr),
        .rd2_addr_i (rd2_addr),
        .wr_en_i    (wb_wr_en),
        .wr_addr_i  (wb_wr_addr),
        .wr_data_i  (wb_data),
        .rd1_data_o (rd1_data),
        .rd2_data_o (rd2_data)
    );

    decode_stage u_decode (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .instr_i       (instr),
        .rd1_data_i    (rd1_data),
        .rd2_data_i    (rd2_data),
        .ex_wr_en_i    (ex_wr_en),
        .ex_is_load_i  (ex_is_load),
        .ex_wr_addr_i  (ex_wr_addr),
        .ex_result_i   (ex_result),
        .mem_wr_en_i   (mem_wr_en),
        .mem_wr_addr_i (mem_wr_addr),
        .mem_result_i  (mem_result),
        .rd1_addr_o    (rd1_addr),
        .rd2_addr_o    (rd2_addr),
        .stall_o       (stall),
        .dec_o         (dec_ex.src)
    );

    execute_stage u_execute (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .dec_i        (dec_ex.dst),
        .ex_wr_en_o   (ex_wr_en),
        .ex_is_load_o (ex_is_load),
        .ex_wr_addr_o (ex_wr_addr),
        .ex_result_o  (ex_result),
        .exm_o        (ex_mem.src)
    );

    memory_stage u_memory (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .exm_i         (ex_mem.dst),
        .ram_rdata_i   (ram_rdata_i),
        .ram_addr_o    (ram_addr_o),
        .ram_wdata_o   (ram_wdata_o),
        .ram_en_o      (ram_en_o),
        .ram_we_o      (ram_we_o),
        .mem_wr_en_o   (mem_wr_en),
        .mem_wr_addr_o (mem_wr_addr),
        .mem_result_o  (mem_result),
        .wb_wr_en_o    (wb_wr_en),
        .wb_wr_addr_o  (wb_wr_addr),
        .wb_data_o     (wb_data)
    );

endmodule

`default_nettype wire

//--- mips_pkg.sv
// shared types, opcode and funct encodings, ALU operation codes
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [3:0]  alu_op_t;

    // major opcodes
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    // R-type function field
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_SLT  = 6'h2a;

    // ALU operations
    localparam alu_op_t ALU_ADD = 4'd0;
    localparam alu_op_t ALU_SUB = 4'd1;
    localparam alu_op_t ALU_AND = 4'd2;
    localparam alu_op_t ALU_OR  = 4'd3;
    localparam alu_op_t ALU_XOR = 4'd4;
    localparam alu_op_t ALU_SLT = 4'd5;
    localparam alu_op_t ALU_LUI = 4'd6;

endpackage

`default_nettype wire

//--- reg_file.sv
// 32 x 32 register file, two read ports, one write port with write-through
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                arst_n_i,
    input  mips_pkg::reg_addr_t rd1_addr_i,
    input  mips_pkg::reg_addr_t rd2_addr_i,
    input  logic                wr_en_i,
    input  mips_pkg::reg_addr_t wr_addr_i,
    input  mips_pkg::word_t     wr_data_i,
    output mips_pkg::word_t     rd1_data_o,
    output mips_pkg::word_t     rd2_data_o
);

    mips_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // $0 is hardwired, a same-cycle write wins over the array
    always_comb begin
        if (rd1_addr_i == '0) begin
            rd1_data_o = '0;
        end else if (wr_en_i && wr_addr_i == rd1_addr_i) begin
            rd1_data_o = wr_data_i;
        end else begin
            rd1_data_o = regs[rd1_addr_i];
        end
        if (rd2_addr_i == '0) begin
            rd2_data_o = '0;
        end else if (wr_en_i && wr_addr_i == rd2_addr_i) begin
            rd2_data_o = wr_data_i;
        end else begin
            rd2_data_o = regs[rd2_addr_i];
        end
    end

    a_zero_rd1: assert property (@(posedge clk) disable iff (!arst_n_i)
        rd1_addr_i == '0 |-> rd1_data_o == '0);

    a_zero_rd2: assert property (@(posedge clk) disable iff (!arst_n_i)
        rd2_addr_i == '0 |-> rd2_data_o == '0);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the MIPS core testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mips_core -Mdir obj_dir -f mips_core.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_mips_core > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Checks failed" "$log"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation finished cleanly"
exit 0

//--- tb_mips_core.sv
// testbench for the pipelined MIPS core
// ROM/RAM models, LFSR, reference ALU, compare tasks and directed tests
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

    localparam int              NUM_TESTS      = 6;
    localparam int              TIMEOUT_CYCLES = 200 * NUM_TESTS;
    localparam mips_pkg::word_t NOP            = 32'h0000_0000;

    logic            clk;
    logic            arst_n_i;
    mips_pkg::word_t rom_data_i;
    mips_pkg::word_t ram_rdata_i;
    mips_pkg::word_t rom_addr_o;
    logic            rom_en_o;
    mips_pkg::word_t ram_addr_o;
    mips_pkg::word_t ram_wdata_o;
    logic            ram_en_o;
    logic            ram_we_o;

    mips_pkg::word_t rom [64];
    mips_pkg::word_t ram [64];
    mips_pkg::word_t prog [$];
    mips_pkg::word_t st_addr [$];
    mips_pkg::word_t st_data [$];
    mips_pkg::word_t exp_addr [$];
    mips_pkg::word_t exp_data [$];
    mips_pkg::word_t lfsr;
    int              cycles = 0;

    mips_core #(
        .RESET_PC (32'h0000_0000)
    ) dut0 (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .rom_data_i  (rom_data_i),
        .ram_rdata_i (ram_rdata_i),
        .rom_addr_o  (rom_addr_o),
        .rom_en_o    (rom_en_o),
        .ram_addr_o  (ram_addr_o),
        .ram_wdata_o (ram_wdata_o),
        .ram_en_o    (ram_en_o),
        .ram_we_o    (ram_we_o)
    );

    // fetches past the 64-word ROM return NOPs
    assign rom_data_i  = (rom_en_o && rom_addr_o[31:8] == 24'h0) ? rom[rom_addr_o[7:2]] : NOP;
    assign ram_rdata_i = ram[ram_addr_o[7:2]];

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Checks failed");
            $fatal(1, "timeout: tests still running after %0d cycles", cycles);
        end
    end

    // store log and RAM write at the clock edge
    always @(posedge clk) begin
        if (ram_en_o && ram_we_o) begin
            st_addr.push_back(ram_addr_o);
            st_data.push_back(ram_wdata_o);
            ram[ram_addr_o[7:2]] = ram_wdata_o;
        end
    end

    task automatic report_mismatch(input string what, input mips_pkg::word_t got,
                                   input mips_pkg::word_t exp);
        $display("MISMATCH at time %0t: %s, got %h, expected %h", $time, what, got, exp);
        $display("Checks failed");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic check_word(input mips_pkg::word_t got, input mips_pkg::word_t exp,
                              input string what);
        if (got !== exp) report_mismatch(what, got, exp);
    endtask

    task automatic check_addr(input mips_pkg::word_t got, input mips_pkg::word_t exp,
                              input string what);
        if (got !== exp) report_mismatch(what, got, exp);
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) report_mismatch(what, {31'b0, got}, {31'b0, exp});
    endtask

    function automatic mips_pkg::word_t lfsr_next(input mips_pkg::word_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic mips_pkg::word_t take_bits(input int n);
        mips_pkg::word_t r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic mips_pkg::word_t sign_ext(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic mips_pkg::word_t zero_ext(input logic [15:0] imm);
        return {16'h0000, imm};
    endfunction

    // reference ALU, SLT compares signed
    function automatic mips_pkg::word_t alu_model(input mips_pkg::funct_t fn,
                                                  input mips_pkg::word_t a,
                                                  input mips_pkg::word_t b);
        case (fn)
            mips_pkg::FN_ADDU: return a + b;
            mips_pkg::FN_SUBU: return a - b;
            mips_pkg::FN_AND:  return a & b;
            mips_pkg::FN_OR:   return a | b;
            mips_pkg::FN_XOR:  return a ^ b;
            mips_pkg::FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:           return 32'd0;
        endcase
    endfunction

    function automatic mips_pkg::word_t r_instr(input mips_pkg::funct_t fn,
                                                input mips_pkg::reg_addr_t rd,
                                                input mips_pkg::reg_addr_t rs,
                                                input mips_pkg::reg_addr_t rt);
        return {mips_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic mips_pkg::word_t i_instr(input mips_pkg::opcode_t op,
                                                input mips_pkg::reg_addr_t rt,
                                                input mips_pkg::reg_addr_t rs,
                                                input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic load_const(input mips_pkg::reg_addr_t rt, input mips_pkg::word_t v);
        prog.push_back(i_instr(mips_pkg::OP_LUI, rt, 5'd0, v[31:16]));
        prog.push_back(i_instr(mips_pkg::OP_ORI, rt, rt, v[15:0]));
    endtask

    task automatic store_reg(input mips_pkg::reg_addr_t rt, input logic [15:0] offset,
                             input mips_pkg::word_t value);
        prog.push_back(i_instr(mips_pkg::OP_SW, rt, 5'd0, offset));
        exp_addr.push_back(zero_ext(offset));
        exp_data.push_back(value);
    endtask

    task automatic check_strobes_low(input string when);
        check_flag(rom_en_o, 1'b0, {"rom_en_o ", when});
        check_flag(ram_en_o, 1'b0, {"ram_en_o ", when});
        check_flag(ram_we_o, 1'b0, {"ram_we_o ", when});
    endtask

    // load the program under reset, hold 3 cycles, release
    task automatic run_program;
        @(negedge clk);
        arst_n_i = 1'b0;
        for (int i = 0; i < 64; i++) begin
            rom[i[5:0]] = (i < prog.size()) ? prog[i] : NOP;
            ram[i[5:0]] = '0;
        end
        st_addr.delete();
        st_data.delete();
        repeat (3) begin
            @(negedge clk);
            check_strobes_low("during reset");
        end
        arst_n_i = 1'b1;
        // look once the release has settled, before the next rising edge
        #10;
        check_strobes_low("in the release cycle");
    endtask

    task automatic check_stores;
        while (st_addr.size() < exp_addr.size()) @(negedge clk);
        for (int i = 0; i < exp_addr.size(); i++) begin
            check_addr(st_addr[i], exp_addr[i], $sformatf("store %0d address", i));
            check_word(st_data[i], exp_data[i], $sformatf("store %0d data", i));
        end
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic test_reset;
        run_program;
        for (int k = 0; k < 5; k++) begin
            @(negedge clk);
            check_flag(rom_en_o, 1'b1, "rom_en_o after reset");
            check_addr(rom_addr_o, mips_pkg::word_t'(4 * k), "fetch address");
            check_flag(ram_en_o, 1'b0, "ram_en_o while running NOPs");
        end
    endtask

    task automatic test_immediates;
        mips_pkg::word_t r1;
        r1 = alu_model(mips_pkg::FN_OR, {16'h1234, 16'h0000}, zero_ext(16'h5678));
        prog.push_back(i_instr(mips_pkg::OP_LUI, 1, 0, 16'h1234));
        prog.push_back(i_instr(mips_pkg::OP_ORI, 1, 1, 16'h5678));
        prog.push_back(i_instr(mips_pkg::OP_ADDIU, 2, 0, 16'hfff0));
        prog.push_back(i_instr(mips_pkg::OP_ANDI, 3, 1, 16'hff0f));
        prog.push_back(i_instr(mips_pkg::OP_ADDIU, 4, 1, 16'h8000));
        prog.push_back(i_instr(mips_pkg::OP_ORI, 5, 0, 16'h8001));
        store_reg(1, 16'd0, r1);
        store_reg(2, 16'd4, alu_model(mips_pkg::FN_ADDU, 32'h0, sign_ext(16'hfff0)));
        store_reg(3, 16'd8, alu_model(mips_pkg::FN_AND, r1, zero_ext(16'hff0f)));
        store_reg(4, 16'd12, alu_model(mips_pkg::FN_ADDU, r1, sign_ext(16'h8000)));
        store_reg(5, 16'd16, alu_model(mips_pkg::FN_OR, 32'h0, zero_ext(16'h8001)));
        run_program;
        check_stores;
    endtask

    // each operation reads the result of the one before
    task automatic test_dependencies;
        mips_pkg::word_t r [9];
        r[1] = 32'h8765_4321;
        r[2] = 32'h1357_9bdf;
        r[3] = alu_model(mips_pkg::FN_ADDU, r[1], r[2]);
        r[4] = alu_model(mips_pkg::FN_SUBU, r[3], r[2]);
        r[5] = alu_model(mips_pkg::FN_XOR, r[4], r[3]);
        r[6] = alu_model(mips_pkg::FN_AND, r[5], r[1]);
        r[7] = alu_model(mips_pkg::FN_OR, r[6], r[2]);
        r[8] = alu_model(mips_pkg::FN_SLT, r[1], r[7]);
        load_const(1, r[1]);
        load_const(2, r[2]);
        prog.push_back(r_instr(mips_pkg::FN_ADDU, 3, 1, 2));
        prog.push_back(r_instr(mips_pkg::FN_SUBU, 4, 3, 2));
        prog.push_back(r_instr(mips_pkg::FN_XOR, 5, 4, 3));
        prog.push_back(r_instr(mips_pkg::FN_AND, 6, 5, 1));
        prog.push_back(r_instr(mips_pkg::FN_OR, 7, 6, 2));
        prog.push_back(r_instr(mips_pkg::FN_SLT, 8, 1, 7));
        store_reg(8, 16'd0, r[8]);
        for (int k = 3; k < 8; k++) begin
            store_reg(mips_pkg::reg_addr_t'(k), 16'(4 * (k - 2)), r[k]);
        end
        run_program;
        check_stores;
    endtask

    task automatic test_load_use;
        mips_pkg::word_t v;
        mips_pkg::word_t sum;
        v   = alu_model(mips_pkg::FN_OR, 32'h0, zero_ext(16'h0123));
        sum = alu_model(mips_pkg::FN_ADDU, v, v);
        prog.push_back(i_instr(mips_pkg::OP_ORI, 1, 0, 16'h0123));
        store_reg(1, 16'd32, v);
        prog.push_back(i_instr(mips_pkg::OP_LW, 2, 0, 16'd32));
        prog.push_back(r_instr(mips_pkg::FN_ADDU, 3, 2, 1));
        store_reg(3, 16'd36, sum);
        // store data taken straight from a load
        prog.push_back(i_instr(mips_pkg::OP_LW, 4, 0, 16'd36));
        store_reg(4, 16'd40, sum);
        run_program;
        check_stores;
    endtask

    task automatic test_zero_reg;
        prog.push_back(i_instr(mips_pkg::OP_ADDIU, 0, 0, 16'h0055));
        store_reg(0, 16'd44, 32'h0);
        prog.push_back(i_instr(mips_pkg::OP_ORI, 0, 0, 16'h0007));
        prog.push_back(r_instr(mips_pkg::FN_ADDU, 1, 0, 0));
        store_reg(1, 16'd48, 32'h0);
        run_program;
        check_stores;
    endtask

    task automatic test_random_alu;
        mips_pkg::word_t  a;
        mips_pkg::word_t  b;
        mips_pkg::word_t  sel;
        mips_pkg::funct_t fn;
        for (int i = 0; i < 12; i++) begin
            a   = take_bits(32);
            b   = take_bits(32);
            sel = take_bits(3);
            case (sel % 6)
                0:       fn = mips_pkg::FN_ADDU;
                1:       fn = mips_pkg::FN_SUBU;
                2:       fn = mips_pkg::FN_AND;
                3:       fn = mips_pkg::FN_OR;
                4:       fn = mips_pkg::FN_XOR;
                default: fn = mips_pkg::FN_SLT;
            endcase
            load_const(1, a);
            load_const(2, b);
            prog.push_back(r_instr(fn, 3, 1, 2));
            store_reg(3, 16'(4 * i), alu_model(fn, a, b));
            run_program;
            check_stores;
        end
    endtask

    initial begin
        arst_n_i = 1'b0;
        lfsr     = 32'hcb1b_e681;
        for (int i = 0; i < 64; i++) begin
            rom[i[5:0]] = NOP;
            ram[i[5:0]] = '0;
        end
        test_reset;
        test_immediates;
        test_dependencies;
        test_load_use;
        test_zero_reg;
        test_random_alu;
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
